// File: design/decode_pkg.sv
// Decode package with shared widths, selector codes and the pipeline records
`default_nettype none

package decode_pkg;

  // Widths with a meaning of their own
  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [3:0]  alu_op_t;
  typedef logic [1:0]  fu_sel_t;
  typedef logic [1:0]  src_a_sel_t;
  typedef logic [1:0]  src_b_sel_t;
  typedef logic [1:0]  wsrc_t;

  localparam int NUM_REGS = 32;

  // Functional unit classes, arith must stay zero for bubbles
  localparam fu_sel_t FU_ARITH     = 2'd0;
  localparam fu_sel_t FU_LOADSTORE = 2'd1;
  localparam fu_sel_t FU_JUMP      = 2'd2;
  localparam fu_sel_t FU_BRANCH    = 2'd3;

  // Operand A sources
  localparam src_a_sel_t SRC_A_RS1   = 2'd0;
  localparam src_a_sel_t SRC_A_IMM_S = 2'd1;
  localparam src_a_sel_t SRC_A_PC    = 2'd2;
  localparam src_a_sel_t SRC_A_ZERO  = 2'd3;

  // Operand B sources
  localparam src_b_sel_t SRC_B_RS1   = 2'd0;
  localparam src_b_sel_t SRC_B_RS2   = 2'd1;
  localparam src_b_sel_t SRC_B_IMM   = 2'd2;
  localparam src_b_sel_t SRC_B_IMM_U = 2'd3;

  // Write-back sources
  localparam wsrc_t WSRC_ALU   = 2'd0;
  localparam wsrc_t WSRC_PC4   = 2'd1;
  localparam wsrc_t WSRC_IMM_U = 2'd2;

  // ALU operations
  localparam alu_op_t ALU_ADD  = 4'd0;
  localparam alu_op_t ALU_SUB  = 4'd1;
  localparam alu_op_t ALU_AND  = 4'd2;
  localparam alu_op_t ALU_OR   = 4'd3;
  localparam alu_op_t ALU_XOR  = 4'd4;
  localparam alu_op_t ALU_SLL  = 4'd5;
  localparam alu_op_t ALU_SRL  = 4'd6;
  localparam alu_op_t ALU_SRA  = 4'd7;
  localparam alu_op_t ALU_SLT  = 4'd8;
  localparam alu_op_t ALU_SLTU = 4'd9;

  // RV32I major opcodes
  localparam logic [6:0] OP_LUI      = 7'b0110111;
  localparam logic [6:0] OP_AUIPC    = 7'b0010111;
  localparam logic [6:0] OP_JAL      = 7'b1101111;
  localparam logic [6:0] OP_JALR     = 7'b1100111;
  localparam logic [6:0] OP_BRANCH   = 7'b1100011;
  localparam logic [6:0] OP_LOAD     = 7'b0000011;
  localparam logic [6:0] OP_STORE    = 7'b0100011;
  localparam logic [6:0] OP_IMM      = 7'b0010011;
  localparam logic [6:0] OP_REG      = 7'b0110011;
  localparam logic [6:0] OP_MISC_MEM = 7'b0001111;
  localparam logic [6:0] OP_SYSTEM   = 7'b1110011;

  // Control unit output, consumed by the decode stage
  typedef struct packed {
    reg_addr_t   rs1;
    reg_addr_t   rs2;
    reg_addr_t   rd;
    logic [11:0] imm_i;
    logic [11:0] imm_s;
    logic [20:0] imm_uj;
    word_t       imm_u;
    logic [4:0]  shamt;
    logic        imm_shamt_sel;
    src_a_sel_t  src_a_sel;
    src_b_sel_t  src_b_sel;
    wsrc_t       wsrc;
    alu_op_t     alu_op;
    fu_sel_t     fu_sel;
    logic        wen;
    logic        j_sel;
    logic        jump;
    logic        branch;
    logic [2:0]  branch_type;
    logic        ifence;
    logic        halt;
    logic        illegal;
  } ctrl_t;

  // ID/EX record, all zeros is a bubble
  typedef struct packed {
    word_t      pc;
    word_t      pc4;
    word_t      port_a;
    word_t      port_b;
    word_t      reg_file_wdata;
    word_t      jump_base;
    word_t      jump_offset;
    reg_addr_t  rd;
    logic       wen;
    alu_op_t    alu_op;
    fu_sel_t    fu_sel;
    logic       jump;
    logic       j_sel;
    logic       branch;
    logic [2:0] branch_type;
    logic       illegal;
    logic       halt_instr;
  } id_ex_t;

endpackage

`default_nettype wire

// File: design/control_unit.sv
// RV32I control unit, slices instruction fields and decodes them into control signals
`timescale 1ns/1ps
`default_nettype none

module control_unit (
  input  decode_pkg::word_t instr,
  output decode_pkg::ctrl_t ctrl
);

  import decode_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  // Shared funct3 map for register and immediate arithmetic
  // alt picks SUB over ADD and SRA over SRL
  function automatic alu_op_t alu_decode(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  alu_decode = alt ? ALU_SUB : ALU_ADD;
      3'b001:  alu_decode = ALU_SLL;
      3'b010:  alu_decode = ALU_SLT;
      3'b011:  alu_decode = ALU_SLTU;
      3'b100:  alu_decode = ALU_XOR;
      3'b101:  alu_decode = alt ? ALU_SRA : ALU_SRL;
      3'b110:  alu_decode = ALU_OR;
      default: alu_decode = ALU_AND;
    endcase
  endfunction

  always_comb begin
    // Everything off unless the opcode says otherwise
    ctrl = '0;

    // Register and immediate fields, valid for every format
    ctrl.rs1    = instr[19:15];
    ctrl.rs2    = instr[24:20];
    ctrl.rd     = instr[11:7];
    ctrl.imm_i  = instr[31:20];
    ctrl.imm_s  = {instr[31:25], instr[11:7]};
    // J format, bit 0 always zero
    ctrl.imm_uj = {instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
    ctrl.imm_u  = {instr[31:12], 12'b0};
    ctrl.shamt  = instr[24:20];

    case (opcode)
      OP_LUI: begin
        // Result comes straight from imm_u
        ctrl.src_a_sel = SRC_A_ZERO;
        ctrl.src_b_sel = SRC_B_IMM_U;
        ctrl.wsrc      = WSRC_IMM_U;
        ctrl.wen       = 1'b1;
      end
      OP_AUIPC: begin
        ctrl.src_a_sel = SRC_A_PC;
        ctrl.src_b_sel = SRC_B_IMM_U;
        ctrl.wen       = 1'b1;
      end
      OP_JAL: begin
        // Link value is pc4, target is pc relative
        ctrl.fu_sel = FU_JUMP;
        ctrl.jump   = 1'b1;
        ctrl.j_sel  = 1'b1;
        ctrl.wsrc   = WSRC_PC4;
        ctrl.wen    = 1'b1;
      end
      OP_JALR: begin
        // Target from rs1 plus I immediate
        ctrl.fu_sel = FU_JUMP;
        ctrl.jump   = 1'b1;
        ctrl.wsrc   = WSRC_PC4;
        ctrl.wen    = 1'b1;
      end
      OP_BRANCH: begin
        // Compare rs1 against rs2
        ctrl.fu_sel      = FU_BRANCH;
        ctrl.branch      = 1'b1;
        ctrl.branch_type = funct3;
        ctrl.src_b_sel   = SRC_B_RS2;
        ctrl.alu_op      = ALU_SUB;
      end
      OP_LOAD: begin
        ctrl.fu_sel    = FU_LOADSTORE;
        ctrl.src_b_sel = SRC_B_IMM;
        ctrl.wen       = 1'b1;
      end
      OP_STORE: begin
        // Address is imm_s on A plus rs1 on B
        ctrl.fu_sel    = FU_LOADSTORE;
        ctrl.src_a_sel = SRC_A_IMM_S;
        ctrl.src_b_sel = SRC_B_RS1;
      end
      OP_IMM: begin
        ctrl.src_b_sel     = SRC_B_IMM;
        // Shifts take shamt instead of the I immediate
        ctrl.imm_shamt_sel = (funct3 == 3'b001) || (funct3 == 3'b101);
        ctrl.alu_op        = alu_decode(funct3, (funct3 == 3'b101) && funct7[5]);
        ctrl.wen           = 1'b1;
      end
      OP_REG: begin
        // Only base funct7 or the SUB/SRA variant is legal
        if ((funct7 == 7'b0000000) ||
            ((funct7 == 7'b0100000) && ((funct3 == 3'b000) || (funct3 == 3'b101)))) begin
          ctrl.src_b_sel = SRC_B_RS2;
          ctrl.alu_op    = alu_decode(funct3, funct7[5]);
          ctrl.wen       = 1'b1;
        end else begin
          ctrl.illegal = 1'b1;
        end
      end
      OP_MISC_MEM: begin
        // Plain fence is a no-op here
        ctrl.ifence = (funct3 == 3'b001);
      end
      OP_SYSTEM: begin
        // ECALL and EBREAK both stop the core
        ctrl.halt = (funct3 == 3'b000) && (instr[31:21] == 11'd0);
      end
      default: begin
        ctrl.illegal = 1'b1;
      end
    endcase
  end

  // Illegal encodings must never write the register file
  always_comb begin
    assert (!(ctrl.illegal && ctrl.wen))
      else $error("control_unit: illegal instruction with wen set");
  end

endmodule

`default_nettype wire

// File: design/reg_file.sv
// Register file, 32 words with x0 tied to zero, two async reads and one write
`timescale 1ns/1ps
`default_nettype none

module reg_file (
  input  logic                  CLK,
  input  logic                  nRST,
  input  decode_pkg::reg_addr_t rs1,
  input  decode_pkg::reg_addr_t rs2,
  output decode_pkg::word_t     rs1_data,
  output decode_pkg::word_t     rs2_data,
  input  logic                  wen,
  input  decode_pkg::reg_addr_t rd,
  input  decode_pkg::word_t     wdata
);

  import decode_pkg::*;

  word_t regs [NUM_REGS];

  // Write at the edge, x0 never written
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && (rd != '0)) begin
      regs[rd] <= wdata;
    end
  end

  // No bypass, same cycle write is not visible
  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];

endmodule

`default_nettype wire

// File: design/fence_tracker.sv
// Fence tracker, one flush pulse per fence.i run and per-cache flush done flags
`timescale 1ns/1ps
`default_nettype none

module fence_tracker (
  input  logic CLK,
  input  logic nRST,
  input  logic ifence,
  input  logic pc_en,
  input  logic iflush_done,
  input  logic dflush_done,
  output logic icache_flush,
  output logic dcache_flush,
  output logic iflushed,
  output logic dflushed,
  output logic ifence_pending
);

  logic       ifence_reg;
  logic       flush_pulse;
  // Bit 0 is the icache, bit 1 the dcache
  logic [1:0] flushed;
  logic [1:0] done;

  // Previous ifence, only advances with the pipeline
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      ifence_reg <= 1'b0;
    end else if (pc_en) begin
      ifence_reg <= ifence;
    end
  end

  // Rising edge only, back-to-back fence.i collapse to one pulse
  assign flush_pulse  = ifence && !ifence_reg;
  assign icache_flush = flush_pulse;
  assign dcache_flush = flush_pulse;

  assign done = {dflush_done, iflush_done};

  // Cleared by the pulse, set by that cache's own done strobe
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      flushed <= 2'b11;
    end else begin
      for (int i = 0; i < 2; i++) begin
        if (flush_pulse) begin
          flushed[i] <= 1'b0;
        end else if (done[i] && pc_en) begin
          flushed[i] <= 1'b1;
        end
      end
    end
  end

  assign iflushed       = flushed[0];
  assign dflushed       = flushed[1];
  assign ifence_pending = !iflushed || !dflushed;

  // Once the pulse is taken, a held fence.i must not pulse again
  assert property (@(posedge CLK) disable iff (!nRST)
    (flush_pulse && pc_en) |=> !(ifence && flush_pulse))
    else $error("fence_tracker: repeated flush pulse during fence.i run");

endmodule

`default_nettype wire

// File: design/decode_stage.sv
// Decode stage, builds operands, write-back value and jump target, then latches ID/EX
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
  input  logic               CLK,
  input  logic               nRST,
  input  decode_pkg::ctrl_t  ctrl,
  input  decode_pkg::word_t  pc,
  input  decode_pkg::word_t  pc4,
  input  decode_pkg::word_t  rs1_data,
  input  decode_pkg::word_t  rs2_data,
  input  logic               pc_en,
  input  logic               stall,
  input  logic               flush,
  input  logic               halt,
  output decode_pkg::id_ex_t id_ex
);

  import decode_pkg::*;

  word_t  imm_i_ext;
  word_t  imm_s_ext;
  word_t  imm_uj_ext;
  word_t  imm_or_shamt;
  word_t  port_a;
  word_t  port_b;
  word_t  wdata;
  word_t  jump_base;
  word_t  jump_offset;
  id_ex_t next_rec;

  // Sign extension of the short immediates
  assign imm_i_ext  = {{20{ctrl.imm_i[11]}}, ctrl.imm_i};
  assign imm_s_ext  = {{20{ctrl.imm_s[11]}}, ctrl.imm_s};
  assign imm_uj_ext = {{11{ctrl.imm_uj[20]}}, ctrl.imm_uj};

  // Shift amount is zero extended
  assign imm_or_shamt = ctrl.imm_shamt_sel ? {27'd0, ctrl.shamt} : imm_i_ext;

  // Operand A
  always_comb begin
    case (ctrl.src_a_sel)
      SRC_A_RS1:   port_a = rs1_data;
      SRC_A_IMM_S: port_a = imm_s_ext;
      SRC_A_PC:    port_a = pc;
      default:     port_a = '0;
    endcase
  end

  // Operand B
  always_comb begin
    case (ctrl.src_b_sel)
      SRC_B_RS1: port_b = rs1_data;
      SRC_B_RS2: port_b = rs2_data;
      SRC_B_IMM: port_b = imm_or_shamt;
      default:   port_b = ctrl.imm_u;
    endcase
  end

  // Write-back value known at decode, zero when the ALU supplies it
  always_comb begin
    case (ctrl.wsrc)
      WSRC_PC4:   wdata = pc4;
      WSRC_IMM_U: wdata = ctrl.imm_u;
      default:    wdata = '0;
    endcase
  end

  // JAL is pc relative, JALR is rs1 relative
  always_comb begin
    if (ctrl.j_sel) begin
      jump_base   = pc;
      jump_offset = imm_uj_ext;
    end else begin
      jump_base   = rs1_data;
      jump_offset = imm_i_ext;
    end
  end

  // Decoded record for the next edge
  always_comb begin
    next_rec.pc             = pc;
    next_rec.pc4            = pc4;
    next_rec.port_a         = port_a;
    next_rec.port_b         = port_b;
    next_rec.reg_file_wdata = wdata;
    next_rec.jump_base      = jump_base;
    next_rec.jump_offset    = jump_offset;
    next_rec.rd             = ctrl.rd;
    next_rec.wen            = ctrl.wen;
    next_rec.alu_op         = ctrl.alu_op;
    next_rec.fu_sel         = ctrl.fu_sel;
    next_rec.jump           = ctrl.jump;
    next_rec.j_sel          = ctrl.j_sel;
    next_rec.branch         = ctrl.branch;
    next_rec.branch_type    = ctrl.branch_type;
    next_rec.illegal        = ctrl.illegal;
    next_rec.halt_instr     = ctrl.halt;
  end

  // ID/EX latch
  // halt wins, then flush or stall under pc_en, else hold with pc_en low
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      id_ex <= '0;
    end else if (halt) begin
      id_ex <= '0;
    end else if (pc_en) begin
      if (flush || stall) begin
        id_ex <= '0;
      end else begin
        id_ex <= next_rec;
      end
    end
  end

  // Halt always leaves a bubble behind it
  assert property (@(posedge CLK) disable iff (!nRST) halt |=> (id_ex == '0))
    else $error("decode_stage: id_ex not a bubble after halt");

endmodule

`default_nettype wire

// File: design/decode_top.sv
// Decode top level, ties control unit, register file, fence tracker and decode stage
`timescale 1ns/1ps
`default_nettype none

module decode_top (
  input  logic                  CLK,
  input  logic                  nRST,
  // From fetch
  input  decode_pkg::word_t     instr,
  input  decode_pkg::word_t     pc,
  input  decode_pkg::word_t     pc4,
  // Hazard levels
  input  logic                  pc_en,
  input  logic                  stall,
  input  logic                  flush,
  input  logic                  halt,
  // Write-back port
  input  logic                  wb_wen,
  input  decode_pkg::reg_addr_t wb_rd,
  input  decode_pkg::word_t     wb_data,
  // Cache done strobes
  input  logic                  iflush_done,
  input  logic                  dflush_done,
  output decode_pkg::id_ex_t    id_ex,
  output logic                  icache_flush,
  output logic                  dcache_flush,
  output logic                  iflushed,
  output logic                  dflushed,
  output logic                  ifence_pending
);

  import decode_pkg::*;

  ctrl_t ctrl;
  word_t rs1_data;
  word_t rs2_data;

  control_unit u_control_unit (
    .instr (instr),
    .ctrl  (ctrl)
  );

  // Read addresses come straight from the decoded fields
  reg_file u_reg_file (
    .CLK      (CLK),
    .nRST     (nRST),
    .rs1      (ctrl.rs1),
    .rs2      (ctrl.rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wen      (wb_wen),
    .rd       (wb_rd),
    .wdata    (wb_data)
  );

  fence_tracker u_fence_tracker (
    .CLK            (CLK),
    .nRST           (nRST),
    .ifence         (ctrl.ifence),
    .pc_en          (pc_en),
    .iflush_done    (iflush_done),
    .dflush_done    (dflush_done),
    .icache_flush   (icache_flush),
    .dcache_flush   (dcache_flush),
    .iflushed       (iflushed),
    .dflushed       (dflushed),
    .ifence_pending (ifence_pending)
  );

  decode_stage u_decode_stage (
    .CLK      (CLK),
    .nRST     (nRST),
    .ctrl     (ctrl),
    .pc       (pc),
    .pc4      (pc4),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .pc_en    (pc_en),
    .stall    (stall),
    .flush    (flush),
    .halt     (halt),
    .id_ex    (id_ex)
  );

endmodule

`default_nettype wire

// File: tests/decode_tb.sv
// Decode stage testbench, random RV32I stimulus checked against a reference model
`timescale 1ns/1ps
`default_nettype none

module decode_tb;

  import decode_pkg::*;

  localparam int CLK_PERIOD   = 4;
  localparam int RESET_CYCLES = 5;
  localparam int N_RANDOM     = 200;
  // Bound on all stimulus cycles, fixed phases included
  localparam int STIM_CYCLES  = RESET_CYCLES + NUM_REGS + N_RANDOM + 48;
  localparam int MARGIN_NS    = 100;

  localparam word_t NOP     = 32'h0000_0013;
  localparam word_t ECALL   = 32'h0000_0073;
  localparam word_t FENCE_I = {17'd0, 3'b001, 5'd0, OP_MISC_MEM};

  logic      CLK;
  logic      nRST;
  word_t     instr;
  word_t     pc;
  word_t     pc4;
  logic      pc_en;
  logic      stall;
  logic      flush;
  logic      halt;
  logic      wb_wen;
  reg_addr_t wb_rd;
  word_t     wb_data;
  logic      iflush_done;
  logic      dflush_done;
  id_ex_t    id_ex;
  logic      icache_flush;
  logic      dcache_flush;
  logic      iflushed;
  logic      dflushed;
  logic      ifence_pending;

  // Reference state, updated on falling edges
  word_t  shadow [NUM_REGS];
  id_ex_t exp_id_ex;
  // Fields left unspecified for jumps and system ops are masked out
  id_ex_t exp_mask;
  logic   exp_ifence_reg;
  logic   exp_iflushed;
  logic   exp_dflushed;
  logic   exp_flush;
  int     pulse_count;
  int     seed;

  decode_top dut (.*);

  assign exp_flush = is_fence_i(instr) && !exp_ifence_reg;

  initial begin
    CLK = 1'b0;
    forever #(CLK_PERIOD / 2) CLK = ~CLK;
  end

  initial begin
    #(STIM_CYCLES * CLK_PERIOD + MARGIN_NS);
    $display("Watchdog expired at %0t ns, the stimulus did not finish", $time);
    abort_run();
  end

  task automatic abort_run();
    $display("TESTS FAILED");
    $fatal(1, "Run stopped on first error");
  endtask

  task automatic report_mismatch(input string name, input logic [255:0] expv,
                                 input logic [255:0] actv);
    $display("[FAIL] t=%0t %s expected %h actual %h", $time, name, expv, actv);
    abort_run();
  endtask

  function automatic logic is_fence_i(input word_t ins);
    is_fence_i = (ins[6:0] == OP_MISC_MEM) && (ins[14:12] == 3'b001);
  endfunction

  // Base funct7, or the alternate one for SUB and SRA
  function automatic logic reg_legal(input word_t ins);
    reg_legal = (ins[31:25] == 7'b0000000) ||
                ((ins[31:25] == 7'b0100000) &&
                 ((ins[14:12] == 3'b000) || (ins[14:12] == 3'b101)));
  endfunction

  function automatic logic ops_defined(input word_t ins);
    case (ins[6:0])
      OP_IMM, OP_LOAD, OP_STORE, OP_LUI, OP_AUIPC: ops_defined = 1'b1;
      OP_REG:  ops_defined = reg_legal(ins);
      default: ops_defined = 1'b0;
    endcase
  endfunction

  // RV32I funct3 meaning for arithmetic
  function automatic alu_op_t alu_expected(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  alu_expected = alt ? ALU_SUB : ALU_ADD;
      3'b001:  alu_expected = ALU_SLL;
      3'b010:  alu_expected = ALU_SLT;
      3'b011:  alu_expected = ALU_SLTU;
      3'b100:  alu_expected = ALU_XOR;
      3'b101:  alu_expected = alt ? ALU_SRA : ALU_SRL;
      3'b110:  alu_expected = ALU_OR;
      default: alu_expected = ALU_AND;
    endcase
  endfunction

  // Expected ID/EX record, reads the shadow registers before this edge's write
  function automatic id_ex_t decoded(input word_t ins, input word_t p, input word_t p4);
    id_ex_t     r;
    logic [2:0] f3;
    word_t      a;
    word_t      b;
    word_t      i_imm;
    word_t      s_imm;
    word_t      j_imm;
    word_t      u_imm;
    r     = '0;
    f3    = ins[14:12];
    a     = shadow[ins[19:15]];
    b     = shadow[ins[24:20]];
    i_imm = {{20{ins[31]}}, ins[31:20]};
    s_imm = {{20{ins[31]}}, ins[31:25], ins[11:7]};
    j_imm = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
    u_imm = {ins[31:12], 12'h000};
    r.pc          = p;
    r.pc4         = p4;
    r.rd          = ins[11:7];
    // Register relative target unless JAL
    r.jump_base   = a;
    r.jump_offset = i_imm;
    case (ins[6:0])
      OP_LUI: begin
        r.port_b         = u_imm;
        r.reg_file_wdata = u_imm;
        r.wen            = 1'b1;
      end
      OP_AUIPC: begin
        r.port_a = p;
        r.port_b = u_imm;
        r.wen    = 1'b1;
      end
      OP_JAL: begin
        r.fu_sel         = FU_JUMP;
        r.jump           = 1'b1;
        r.j_sel          = 1'b1;
        r.reg_file_wdata = p4;
        r.wen            = 1'b1;
        r.jump_base      = p;
        r.jump_offset    = j_imm;
      end
      OP_JALR: begin
        r.fu_sel         = FU_JUMP;
        r.jump           = 1'b1;
        r.reg_file_wdata = p4;
        r.wen            = 1'b1;
      end
      OP_BRANCH: begin
        r.fu_sel      = FU_BRANCH;
        r.branch      = 1'b1;
        r.branch_type = f3;
      end
      OP_LOAD: begin
        r.fu_sel = FU_LOADSTORE;
        r.port_a = a;
        r.port_b = i_imm;
        r.wen    = 1'b1;
      end
      OP_STORE: begin
        r.fu_sel = FU_LOADSTORE;
        r.port_a = s_imm;
        r.port_b = a;
      end
      OP_IMM: begin
        r.port_a = a;
        // Shift immediates carry only shamt
        r.port_b = ((f3 == 3'b001) || (f3 == 3'b101)) ? {27'd0, ins[24:20]} : i_imm;
        r.alu_op = alu_expected(f3, (f3 == 3'b101) && ins[30]);
        r.wen    = 1'b1;
      end
      OP_REG: begin
        if (reg_legal(ins)) begin
          r.port_a = a;
          r.port_b = b;
          r.alu_op = alu_expected(f3, ins[30]);
          r.wen    = 1'b1;
        end else begin
          r.illegal = 1'b1;
        end
      end
      OP_MISC_MEM: begin
      end
      OP_SYSTEM: begin
        r.halt_instr = (f3 == 3'b000) && (ins[31:21] == 11'd0);
      end
      default: begin
        r.illegal = 1'b1;
      end
    endcase
    decoded = r;
  endfunction

  // Applies one edge of the latch, fence and register file rules
  task automatic advance_model();
    id_ex_t nxt;
    logic   pulse;
    nxt   = decoded(instr, pc, pc4);
    pulse = is_fence_i(instr) && !exp_ifence_reg;
    if (halt || (pc_en && (flush || stall))) begin
      exp_id_ex = '0;
      exp_mask  = '1;
    end else if (pc_en) begin
      exp_id_ex = nxt;
      exp_mask  = '1;
      if (!ops_defined(instr)) begin
        exp_mask.port_a = '0;
        exp_mask.port_b = '0;
        exp_mask.alu_op = '0;
      end
    end
    if (pulse) begin
      exp_iflushed = 1'b0;
      exp_dflushed = 1'b0;
    end else begin
      if (iflush_done && pc_en) exp_iflushed = 1'b1;
      if (dflush_done && pc_en) exp_dflushed = 1'b1;
    end
    if (pc_en) exp_ifence_reg = is_fence_i(instr);
    if (wb_wen && (wb_rd != '0)) shadow[wb_rd] = wb_data;
  endtask

  task automatic tick();
    @(negedge CLK);
    advance_model();
  endtask

  // One instruction at a random word aligned pc
  task automatic issue(input word_t ins);
    word_t w;
    w     = $random(seed);
    instr = ins;
    pc    = {w[31:2], 2'b00};
    pc4   = {w[31:2], 2'b00} + 32'd4;
    tick();
  endtask

  task automatic random_alu_mem();
    word_t      r;
    word_t      w;
    word_t      ins;
    logic [6:0] f7;
    r  = $random(seed);
    w  = $random(seed);
    f7 = w[2] ? 7'b0100000 : 7'b0000000;
    // Now and then a funct7 that is illegal for OP_REG
    if (w[7:3] == 5'd0) f7 = r[31:25];
    case (w[1:0])
      2'd0:    ins = {r[31:7], OP_IMM};
      2'd1:    ins = {f7, r[24:7], OP_REG};
      2'd2:    ins = {r[31:7], OP_LOAD};
      default: ins = {r[31:7], OP_STORE};
    endcase
    // Same cycle write, must not reach this read
    wb_wen  = w[8];
    wb_rd   = w[13:9];
    wb_data = $random(seed);
    issue(ins);
  endtask

  always @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      pulse_count <= 0;
    end else if (icache_flush && dcache_flush) begin
      pulse_count <= pulse_count + 1;
    end
  end

  record_check: assert property (@(posedge CLK) disable iff (!nRST)
    (id_ex & exp_mask) == (exp_id_ex & exp_mask))
    else report_mismatch("id_ex", 256'($sampled(exp_id_ex & exp_mask)),
                         256'($sampled(id_ex & exp_mask)));

  icache_check: assert property (@(posedge CLK) disable iff (!nRST) icache_flush == exp_flush)
    else report_mismatch("icache_flush", 256'($sampled(exp_flush)),
                         256'($sampled(icache_flush)));

  dcache_check: assert property (@(posedge CLK) disable iff (!nRST) dcache_flush == exp_flush)
    else report_mismatch("dcache_flush", 256'($sampled(exp_flush)),
                         256'($sampled(dcache_flush)));

  iflushed_check: assert property (@(posedge CLK) disable iff (!nRST) iflushed == exp_iflushed)
    else report_mismatch("iflushed", 256'($sampled(exp_iflushed)), 256'($sampled(iflushed)));

  dflushed_check: assert property (@(posedge CLK) disable iff (!nRST) dflushed == exp_dflushed)
    else report_mismatch("dflushed", 256'($sampled(exp_dflushed)), 256'($sampled(dflushed)));

  pending_check: assert property (@(posedge CLK) disable iff (!nRST)
    ifence_pending == !(exp_iflushed && exp_dflushed))
    else report_mismatch("ifence_pending", 256'($sampled(!(exp_iflushed && exp_dflushed))),
                         256'($sampled(ifence_pending)));

  initial begin
    logic [6:0] jump_ops [4];
    word_t      w;
    seed        = 32'hc7c1_9710;
    jump_ops    = '{OP_LUI, OP_AUIPC, OP_JAL, OP_JALR};
    nRST        = 1'b0;
    instr       = NOP;
    pc          = '0;
    pc4         = 32'd4;
    pc_en       = 1'b1;
    stall       = 1'b0;
    flush       = 1'b0;
    halt        = 1'b0;
    wb_wen      = 1'b0;
    wb_rd       = '0;
    wb_data     = '0;
    iflush_done = 1'b0;
    dflush_done = 1'b0;
    for (int i = 0; i < NUM_REGS; i++) shadow[i] = '0;
    exp_id_ex      = '0;
    exp_mask       = '1;
    exp_ifence_reg = 1'b0;
    exp_iflushed   = 1'b1;
    exp_dflushed   = 1'b1;
    repeat (RESET_CYCLES) @(negedge CLK);
    nRST = 1'b1;

    // Fill every register, x0 write must be dropped
    for (int i = 0; i < NUM_REGS; i++) begin
      wb_wen  = 1'b1;
      wb_rd   = reg_addr_t'(i);
      wb_data = $random(seed);
      issue(NOP);
    end
    wb_wen = 1'b0;
    // add x5, x0, x0 and addi x6, x0, 2047
    issue({7'd0, 5'd0, 5'd0, 3'b000, 5'd5, OP_REG});
    issue({12'h7ff, 5'd0, 3'b000, 5'd6, OP_IMM});

    repeat (N_RANDOM) random_alu_mem();
    wb_wen = 1'b0;

    // LUI, AUIPC, JAL, JALR with random fields
    for (int k = 0; k < 8; k++) begin
      w = $random(seed);
      issue({w[31:7], jump_ops[k % 4]});
    end

    // Bubbles under stall and flush
    stall = 1'b1;
    random_alu_mem();
    stall = 1'b0;
    flush = 1'b1;
    random_alu_mem();
    flush  = 1'b0;
    wb_wen = 1'b0;
    issue({12'h123, 5'd7, 3'b000, 5'd9, OP_IMM});
    // Held record with pc_en low
    pc_en = 1'b0;
    repeat (3) issue(NOP);
    halt = 1'b1;
    issue(NOP);
    halt  = 1'b0;
    pc_en = 1'b1;
    issue(ECALL);

    // Run of three fence.i
    repeat (3) issue(FENCE_I);
    issue(NOP);
    pulse_assert: assert (pulse_count == 1)
      else report_mismatch("flush pulse count", 256'(1), 256'(pulse_count));
    // Done strobe ignored while pc_en is low
    pc_en       = 1'b0;
    iflush_done = 1'b1;
    issue(NOP);
    pc_en = 1'b1;
    iflush_done = 1'b0;
    issue(NOP);
    iflush_done = 1'b1;
    issue(NOP);
    iflush_done = 1'b0;
    repeat (2) issue(NOP);
    dflush_done = 1'b1;
    issue(NOP);
    dflush_done = 1'b0;
    issue(NOP);

    // Unknown opcode and an OP_REG with a bad funct7
    w = $random(seed);
    issue({w[31:7], 7'b1111111});
    issue({7'b0000001, w[24:7], OP_REG});
    issue(NOP);
    tick();

    $display("TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: all.f
design/decode_pkg.sv
design/control_unit.sv
design/reg_file.sv
design/fence_tracker.sv
design/decode_stage.sv
design/decode_top.sv
tests/decode_tb.sv

// File: Makefile
# Verilator build and run for the decode stage testbench

VERILATOR ?= verilator
TOP       ?= decode_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= TESTS PASSED

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run check clean

all: check

build: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(BIN)
	$(BIN) 2>&1 | tee $(LOG)

# Pass or fail decided from the log only
check: run
	@grep -qx '$(PASS_MSG)' $(LOG) && echo "check: simulation passed" || \
	  (echo "check: simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
